// File: Bender.yml
package:
  name: mpd

sources:
  - mpd_pkg.sv
  - slot_table.sv
  - header_capture.sv
  - rx_dealer.sv
  - tx_engine.sv
  - mpd_top.sv
  - target: simulation
    files:
      - tb_mpd.sv

// File: header_capture.sv
// Captures the leading header bytes of each received frame and presents them once per frame
`default_nettype none

module header_capture (
  input  wire logic             CLK,
  input  wire logic             RST_N,
  input  wire mpd_pkg::wr_req_t wr,
  output logic                  hdr_valid,
  output mpd_pkg::hdr_u         hdr
);

  // Byte position in the frame, saturates at HDR_LEN
  logic [$clog2(mpd_pkg::HDR_LEN+1)-1:0] cnt;
  logic [$clog2(mpd_pkg::HDR_LEN+1)-1:0] idx;

  // Position of the byte on wr this cycle
  assign idx = wr.first ? '0 : cnt;

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      cnt       <= '0;
      hdr_valid <= 1'b0;
    end else begin
      if (wr.en && idx < mpd_pkg::HDR_LEN)
        cnt <= idx + 1'b1;
      // One pulse per frame, right after the last byte
      hdr_valid <= wr.en && wr.last;
    end
  end

  // Header lanes, held until the next frame starts
  always_ff @(posedge CLK) begin
    // Short frames leave the unused lanes at zero
    if (wr.en && wr.first)
      hdr <= '0;
    if (wr.en && idx < mpd_pkg::HDR_LEN)
      hdr.lanes[idx] <= wr.data;
  end

endmodule

`default_nettype wire

// File: mpd_pkg.sv
// Shared sizes, index types, request structs and header union for the packet dealer
`default_nettype none

package mpd_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================
  // Width of one frame byte
  localparam int BYTE_W    = 8;
  // Frame slots in the packet table
  localparam int NUM_SLOTS = 4;
  // Longest frame in bytes
  localparam int MEM_DEPTH = 64;
  // Header bytes shown to the firewall
  localparam int HDR_LEN   = 20;

  // ==========================================================
  // Index and data types
  // ==========================================================
  typedef logic [BYTE_W-1:0]                byte_t;
  typedef logic [$clog2(NUM_SLOTS)-1:0]     slot_t;
  typedef logic [$clog2(MEM_DEPTH)-1:0]     addr_t;
  // One bit wider than addr_t so a full slot length fits
  typedef logic [$clog2(MEM_DEPTH+1)-1:0]   len_t;

  // One accepted input byte
  typedef struct packed {
    logic  en;
    logic  first;
    logic  last;
    byte_t data;
  } wr_req_t;

  // Byte read from one slot
  typedef struct packed {
    logic  en;
    slot_t slot;
    addr_t addr;
  } rd_req_t;

  // Release of one slot
  typedef struct packed {
    logic  en;
    slot_t slot;
  } free_req_t;

  // Ethernet header fields, network order, first byte at the top
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ether_type;
    logic [47:0] rest;
  } hdr_fields_t;

  // Same 160 bits seen as fields or as frame bytes
  // Lane 0 is the most significant byte, which is dst_mac[47:40]
  typedef union packed {
    hdr_fields_t                fields;
    byte_t [0:HDR_LEN-1]        lanes;
  } hdr_u;

endpackage

`default_nettype wire

// File: mpd_top.sv
// Top level of the packet dealer, connecting table, header capture, receiver and transmitter
`default_nettype none

module mpd_top (
  input  wire logic           CLK,
  input  wire logic           RST_N,
  // Input frame stream
  input  wire logic           rx_valid,
  input  wire mpd_pkg::byte_t rx_data,
  input  wire logic           rx_last,
  output logic                rx_ready,
  // Firewall decision
  input  wire logic           fw_valid,
  input  wire logic           fw_safe,
  // Header towards the firewall
  output logic                hdr_valid,
  output mpd_pkg::hdr_u       hdr,
  // Output frame stream
  output logic                tx_valid,
  output mpd_pkg::byte_t      tx_data,
  output logic                tx_last
);

  mpd_pkg::wr_req_t   wr;
  mpd_pkg::free_req_t rx_free;
  mpd_pkg::free_req_t tx_free;
  mpd_pkg::rd_req_t   rd;
  mpd_pkg::slot_t     free_slot;
  logic               any_free;
  mpd_pkg::byte_t     rd_data;
  mpd_pkg::len_t      slot_len;
  logic               push;
  mpd_pkg::slot_t     push_slot;

  // ==========================================================
  // Blocks
  // ==========================================================
  slot_table i_slot_table (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .wr        (wr),
    .rx_free   (rx_free),
    .tx_free   (tx_free),
    .rd        (rd),
    .free_slot (free_slot),
    .any_free  (any_free),
    .rd_data   (rd_data),
    .slot_len  (slot_len)
  );

  header_capture i_header_capture (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .wr        (wr),
    .hdr_valid (hdr_valid),
    .hdr       (hdr)
  );

  rx_dealer i_rx_dealer (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .fw_valid  (fw_valid),
    .fw_safe   (fw_safe),
    .free_slot (free_slot),
    .any_free  (any_free),
    .wr        (wr),
    .rx_free   (rx_free),
    .push      (push),
    .push_slot (push_slot)
  );

  tx_engine i_tx_engine (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .push      (push),
    .push_slot (push_slot),
    .rd        (rd),
    .rd_data   (rd_data),
    .slot_len  (slot_len),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_data   (tx_data),
    .tx_free   (tx_free)
  );

endmodule

`default_nettype wire

// File: rx_dealer.sv
// Receive controller that stores each input frame and acts on the firewall decision
`default_nettype none

module rx_dealer (
  input  wire logic             CLK,
  input  wire logic             RST_N,
  input  wire logic             rx_valid,
  input  wire mpd_pkg::byte_t   rx_data,
  input  wire logic             rx_last,
  output logic                  rx_ready,
  input  wire logic             fw_valid,
  input  wire logic             fw_safe,
  input  wire mpd_pkg::slot_t   free_slot,
  input  wire logic             any_free,
  output mpd_pkg::wr_req_t      wr,
  output mpd_pkg::free_req_t    rx_free,
  output logic                  push,
  output mpd_pkg::slot_t        push_slot
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RECV,
    S_WAIT_FW
  } state_t;

  state_t         state;
  logic           accept;
  logic           free_en;
  // Slot taken by the frame now in flight
  mpd_pkg::slot_t cur_slot;

  // ==========================================================
  // Input side
  // ==========================================================
  // Idle takes a new frame only with a slot to put it in
  assign rx_ready = (state == S_IDLE && any_free) || state == S_RECV;
  assign accept   = rx_valid && rx_ready;

  always_comb begin
    wr.en    = accept;
    wr.first = accept && state == S_IDLE;
    wr.last  = accept && rx_last;
    wr.data  = rx_data;
  end

  // ==========================================================
  // Frame FSM
  // ==========================================================
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      state    <= S_IDLE;
      cur_slot <= '0;
      push     <= 1'b0;
      free_en  <= 1'b0;
    end else begin
      // Decision strobes last one cycle
      push    <= 1'b0;
      free_en <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            cur_slot <= free_slot;
            state    <= rx_last ? S_WAIT_FW : S_RECV;
          end
        end
        S_RECV: begin
          if (accept && rx_last)
            state <= S_WAIT_FW;
        end
        S_WAIT_FW: begin
          // Safe goes to the transmit queue, unsafe is dropped
          if (fw_valid) begin
            push    <= fw_safe;
            free_en <= !fw_safe;
            state   <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // cur_slot stays put until the next first byte, past the decision cycle
  assign push_slot = cur_slot;

  always_comb begin
    rx_free.en   = free_en;
    rx_free.slot = cur_slot;
  end

  // Firewall only answers a header that is pending
  a_fw_in_wait: assert property (@(posedge CLK) disable iff (!RST_N)
    fw_valid |-> state == S_WAIT_FW)
    else $error("firewall decision outside wait state");

endmodule

`default_nettype wire

// File: slot_table.sv
// Packet table holding frame bytes per slot, with valid bits, lengths and free slot search
`default_nettype none

module slot_table (
  input  wire logic               CLK,
  input  wire logic               RST_N,
  input  wire mpd_pkg::wr_req_t   wr,
  input  wire mpd_pkg::free_req_t rx_free,
  input  wire mpd_pkg::free_req_t tx_free,
  input  wire mpd_pkg::rd_req_t   rd,
  output mpd_pkg::slot_t          free_slot,
  output logic                    any_free,
  output mpd_pkg::byte_t          rd_data,
  output mpd_pkg::len_t           slot_len
);

  // ==========================================================
  // Storage
  // ==========================================================
  mpd_pkg::byte_t mem [mpd_pkg::NUM_SLOTS][mpd_pkg::MEM_DEPTH];
  mpd_pkg::len_t  len [mpd_pkg::NUM_SLOTS];

  // Slot holds a complete frame
  logic [mpd_pkg::NUM_SLOTS-1:0] valid;

  // Frame under reception
  logic           writing;
  mpd_pkg::slot_t wr_slot;
  mpd_pkg::addr_t wr_addr;

  // Target of the byte on wr this cycle
  mpd_pkg::slot_t cur_slot;
  mpd_pkg::addr_t cur_addr;

  // First byte opens the slot found free, at address zero
  assign cur_slot = wr.first ? free_slot : wr_slot;
  assign cur_addr = wr.first ? '0 : wr_addr;

  // ==========================================================
  // Free slot search
  // ==========================================================
  always_comb begin
    free_slot = '0;
    any_free  = 1'b0;
    // Walk downwards so the lowest free slot wins
    for (int s = mpd_pkg::NUM_SLOTS - 1; s >= 0; s--) begin
      if (!valid[s] && !(writing && wr_slot == mpd_pkg::slot_t'(s))) begin
        free_slot = mpd_pkg::slot_t'(s);
        any_free  = 1'b1;
      end
    end
  end

  // Length of the slot being read, used by the sequencer
  assign slot_len = len[rd.slot];

  // ==========================================================
  // Slot state
  // ==========================================================
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      valid   <= '0;
      writing <= 1'b0;
      wr_slot <= '0;
      wr_addr <= '0;
    end else begin
      if (wr.en) begin
        wr_slot <= cur_slot;
        wr_addr <= cur_addr + mpd_pkg::addr_t'(1);
        if (wr.first)
          writing <= 1'b1;
        // Last byte closes the frame and publishes the slot
        if (wr.last) begin
          writing         <= 1'b0;
          valid[cur_slot] <= 1'b1;
        end
      end
      // Releases from the firewall path and the transmit path
      if (rx_free.en)
        valid[rx_free.slot] <= 1'b0;
      if (tx_free.en)
        valid[tx_free.slot] <= 1'b0;
    end
  end

  // Byte memory, lengths and registered read port
  always_ff @(posedge CLK) begin
    if (wr.en)
      mem[cur_slot][cur_addr] <= wr.data;
    if (wr.en && wr.last)
      len[cur_slot] <= mpd_pkg::len_t'(cur_addr) + mpd_pkg::len_t'(1);
    if (rd.en)
      rd_data <= mem[rd.slot][rd.addr];
  end

  // ==========================================================
  // Checks
  // ==========================================================
  // Receiver only opens a frame when a slot is available
  a_first_needs_free: assert property (@(posedge CLK) disable iff (!RST_N)
    wr.en && wr.first |-> any_free)
    else $error("frame started with no free slot");

  // Both release paths only hit slots that hold a frame
  a_rx_free_valid: assert property (@(posedge CLK) disable iff (!RST_N)
    rx_free.en |-> valid[rx_free.slot])
    else $error("rx free of an empty slot");

  a_tx_free_valid: assert property (@(posedge CLK) disable iff (!RST_N)
    tx_free.en |-> valid[tx_free.slot])
    else $error("tx free of an empty slot");

  // Address wraps to zero only after MEM_DEPTH bytes
  a_no_overflow: assert property (@(posedge CLK) disable iff (!RST_N)
    wr.en && !wr.first |-> writing && wr_addr != '0)
    else $error("frame longer than slot");

endmodule

`default_nettype wire

// File: tb_mpd.sv
// Testbench for the packet dealer with random frames, a firewall model and assertion checks
`default_nettype none

module tb_mpd;
  timeunit 1ns;
  timeprecision 1ps;

  // Run length from the number of frames and their worst-case length
  localparam int RESET_CYCLES   = 8;
  localparam int B2B_FRAMES     = 6;
  localparam int GAP_FRAMES     = 14;
  localparam int NUM_FRAMES     = B2B_FRAMES + GAP_FRAMES;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_FRAMES * (2 * mpd_pkg::MEM_DEPTH + 10);

  logic           CLK;
  logic           RST_N;
  logic           rx_valid;
  mpd_pkg::byte_t rx_data;
  logic           rx_last;
  logic           rx_ready;
  logic           fw_valid;
  logic           fw_safe;
  logic           hdr_valid;
  mpd_pkg::hdr_u  hdr;
  logic           tx_valid;
  mpd_pkg::byte_t tx_data;
  logic           tx_last;

  // Expected header of the last completed frame
  logic [47:0] exp_dst;
  logic [47:0] exp_src;
  logic [15:0] exp_type;
  logic [47:0] exp_rest;
  // Bytes of the frame waiting for its decision
  mpd_pkg::byte_t pend [mpd_pkg::MEM_DEPTH];
  int             pend_len;
  // Approved bytes in decision order as {last, data}
  logic [8:0] exp_q [$];
  logic [8:0] exp_head;
  logic       exp_any;
  // Set from hdr_valid until the decision cycle has passed
  logic       wait_fw;
  // Frames sent but not yet dropped or fully transmitted
  int open_frames;
  int err_cnt;
  int pass_tests;
  int fail_tests;
  int cycles;

  mpd_top i_dut (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .fw_valid  (fw_valid),
    .fw_safe   (fw_safe),
    .hdr_valid (hdr_valid),
    .hdr       (hdr),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_last   (tx_last)
  );

  always #50 CLK = ~CLK;

  // ==========================================================
  // Checks
  // ==========================================================
  a_reset_rx_ready: assert property (@(posedge CLK) $rose(RST_N) |-> rx_ready)
    else begin
      err_cnt++;
      $display("Error rx_ready got %h expected 1", $sampled(rx_ready));
    end
  a_reset_tx_valid: assert property (@(posedge CLK) $rose(RST_N) |-> !tx_valid)
    else begin
      err_cnt++;
      $display("Error tx_valid got %h expected 0", $sampled(tx_valid));
    end

  // Header fields against the bytes sent and zero past the frame end
  a_hdr_dst: assert property (@(posedge CLK) disable iff (!RST_N)
    hdr_valid |-> hdr.fields.dst_mac == exp_dst)
    else begin
      err_cnt++;
      $display("Error hdr.dst_mac got %h expected %h", $sampled(hdr.fields.dst_mac), exp_dst);
    end
  a_hdr_src: assert property (@(posedge CLK) disable iff (!RST_N)
    hdr_valid |-> hdr.fields.src_mac == exp_src)
    else begin
      err_cnt++;
      $display("Error hdr.src_mac got %h expected %h", $sampled(hdr.fields.src_mac), exp_src);
    end
  a_hdr_type: assert property (@(posedge CLK) disable iff (!RST_N)
    hdr_valid |-> hdr.fields.ether_type == exp_type)
    else begin
      err_cnt++;
      $display("Error hdr.ether_type got %h expected %h", $sampled(hdr.fields.ether_type),
               exp_type);
    end
  a_hdr_rest: assert property (@(posedge CLK) disable iff (!RST_N)
    hdr_valid |-> hdr.fields.rest == exp_rest)
    else begin
      err_cnt++;
      $display("Error hdr.rest got %h expected %h", $sampled(hdr.fields.rest), exp_rest);
    end

  // Header pulse exactly one cycle after the accepted last byte
  a_hdr_after_last: assert property (@(posedge CLK) disable iff (!RST_N)
    rx_valid && rx_ready && rx_last |=> hdr_valid)
    else begin
      err_cnt++;
      $display("hdr_valid missing after the last byte");
    end
  a_hdr_no_extra: assert property (@(posedge CLK) disable iff (!RST_N)
    hdr_valid |-> $past(rx_valid && rx_ready && rx_last))
    else begin
      err_cnt++;
      $display("hdr_valid without a last byte before it");
    end
  a_ready_low: assert property (@(posedge CLK) disable iff (!RST_N) wait_fw |-> !rx_ready)
    else begin
      err_cnt++;
      $display("Error rx_ready got %h expected 0", $sampled(rx_ready));
    end

  // Transmit stream against the approved bytes
  a_tx_expected: assert property (@(posedge CLK) disable iff (!RST_N) tx_valid |-> exp_any)
    else begin
      err_cnt++;
      $display("tx byte sent with no approved frame pending");
    end
  a_tx_data: assert property (@(posedge CLK) disable iff (!RST_N)
    tx_valid && exp_any |-> tx_data == exp_head[7:0])
    else begin
      err_cnt++;
      $display("Error tx_data got %h expected %h", $sampled(tx_data), $sampled(exp_head[7:0]));
    end
  a_tx_last: assert property (@(posedge CLK) disable iff (!RST_N)
    tx_valid && exp_any |-> tx_last == exp_head[8])
    else begin
      err_cnt++;
      $display("Error tx_last got %h expected %h", $sampled(tx_last), $sampled(exp_head[8]));
    end
  a_tx_no_gap: assert property (@(posedge CLK) disable iff (!RST_N)
    tx_valid && !tx_last |=> tx_valid)
    else begin
      err_cnt++;
      $display("tx frame has a gap before its last byte");
    end

  // ==========================================================
  // Models
  // ==========================================================
  function automatic void refresh_head();
    exp_any  = exp_q.size() != 0;
    exp_head = exp_q.size() != 0 ? exp_q[0] : '0;
  endfunction

  // Retire one expected byte per tx byte on the edge that samples it
  always @(posedge CLK) begin
    if (RST_N && tx_valid && exp_q.size() != 0) begin
      if (exp_q[0][8])
        open_frames--;
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  // Firewall answers each header 1 to 5 cycles later
  task automatic answer_firewall();
    int   delay;
    logic safe;
    forever begin
      @(posedge CLK);
      #10;
      if (hdr_valid) begin
        wait_fw = 1'b1;
        delay   = $urandom % 5 + 1;
        repeat (delay) @(posedge CLK);
        #10;
        safe     = $urandom % 2;
        fw_valid = 1'b1;
        fw_safe  = safe;
        // Approved bytes join the tx expectation in decision order
        if (safe) begin
          for (int i = 0; i < pend_len; i++)
            exp_q.push_back({i == pend_len - 1, pend[i]});
          refresh_head();
        end else begin
          open_frames--;
        end
        @(posedge CLK);
        #10;
        fw_valid = 1'b0;
        fw_safe  = 1'b0;
        wait_fw  = 1'b0;
      end
    end
  endtask

  // ==========================================================
  // Stimulus
  // ==========================================================
  task automatic send_frame(input int len);
    mpd_pkg::byte_t data [mpd_pkg::MEM_DEPTH];
    mpd_pkg::byte_t b;
    int             i;
    logic           taken;
    for (i = 0; i < len; i++)
      data[i] = mpd_pkg::byte_t'($urandom);
    i = 0;
    while (i < len) begin
      rx_valid = 1'b1;
      rx_data  = data[i];
      rx_last  = (i == len - 1);
      // rx_ready only moves on clock edges
      taken = rx_ready;
      @(posedge CLK);
      #10;
      if (taken)
        i++;
    end
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    rx_data  = '0;
    // Header in network order with bytes past the end read as zero
    for (int k = 0; k < mpd_pkg::HDR_LEN; k++) begin
      b = (k < len) ? data[k] : 8'h00;
      if (k < 6)
        exp_dst = {exp_dst[39:0], b};
      else if (k < 12)
        exp_src = {exp_src[39:0], b};
      else if (k < 14)
        exp_type = {exp_type[7:0], b};
      else
        exp_rest = {exp_rest[39:0], b};
    end
    for (int k = 0; k < len; k++)
      pend[k] = data[k];
    pend_len = len;
    open_frames++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = err_cnt - errs_before;
    if (errs == 0) begin
      pass_tests++;
      $display("Test %s finished with no errors", name);
    end else begin
      fail_tests++;
      $display("Test %s finished with %0d errors", name, errs);
    end
  endtask

  // Frames with idle gaps up to max_gap, then wait until all are dropped or sent
  task automatic run_frames(input string name, input int count, input int max_gap);
    int errs_before;
    int gap;
    errs_before = err_cnt;
    for (int f = 0; f < count; f++) begin
      send_frame($urandom % mpd_pkg::MEM_DEPTH + 1);
      gap = (max_gap == 0) ? 0 : $urandom % (max_gap + 1);
      repeat (gap) begin
        @(posedge CLK);
        #10;
      end
    end
    while (open_frames != 0) begin
      @(posedge CLK);
      #10;
    end
    report_test(name, errs_before);
  endtask

  // Bounded run
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Run stopped after %0d cycles with %0d frames still open", cycles, open_frames);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(53));
    CLK         = 1'b0;
    RST_N       = 1'b0;
    rx_valid    = 1'b0;
    rx_data     = '0;
    rx_last     = 1'b0;
    fw_valid    = 1'b0;
    fw_safe     = 1'b0;
    wait_fw     = 1'b0;
    open_frames = 0;
    err_cnt     = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    refresh_head();
    repeat (RESET_CYCLES) @(posedge CLK);
    #10;
    RST_N = 1'b1;
    fork
      answer_firewall();
    join_none
    // Reset values are checked on the first edge after release
    @(posedge CLK);
    #10;
    report_test("reset_values", 0);
    // More frames than slots in a row, so freed slots must be reused
    run_frames("back_to_back", B2B_FRAMES, 0);
    run_frames("random_gaps", GAP_FRAMES, 4);
    $display("Tests passed %0d, failed %0d, check errors %0d", pass_tests, fail_tests, err_cnt);
    if (err_cnt == 0 && fail_tests == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tx_engine.sv
// Transmit engine with a queue of approved slots that streams each frame out byte by byte
`default_nettype none

module tx_engine (
  input  wire logic             CLK,
  input  wire logic             RST_N,
  input  wire logic             push,
  input  wire mpd_pkg::slot_t   push_slot,
  output mpd_pkg::rd_req_t      rd,
  input  wire mpd_pkg::byte_t   rd_data,
  input  wire mpd_pkg::len_t    slot_len,
  output logic                  tx_valid,
  output logic                  tx_last,
  output mpd_pkg::byte_t        tx_data,
  output mpd_pkg::free_req_t    tx_free
);

  // ==========================================================
  // Queue of approved slots
  // ==========================================================
  mpd_pkg::slot_t                          q [mpd_pkg::NUM_SLOTS];
  mpd_pkg::slot_t                          wptr;
  mpd_pkg::slot_t                          rptr;
  logic [$clog2(mpd_pkg::NUM_SLOTS+1)-1:0] count;

  // Sequencer state
  logic           pop;
  logic           busy;
  logic           issuing;
  logic           last_addr;
  mpd_pkg::slot_t act_slot;
  mpd_pkg::addr_t nxt_addr;
  // Read issued last cycle, data lands in rd_data now
  logic           rd_pend;
  logic           rd_pend_last;
  logic           free_en;

  // Idle engine takes the oldest approved slot
  assign pop = !busy && count != '0;

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push)
        wptr <= wptr + 1'b1;
      if (pop)
        rptr <= rptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (!push && pop)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push)
      q[wptr] <= push_slot;
  end

  // ==========================================================
  // Read sequencer
  // ==========================================================
  // Address zero goes out in the pop cycle itself
  always_comb begin
    rd.en   = pop || issuing;
    rd.slot = pop ? q[rptr] : act_slot;
    rd.addr = pop ? '0 : nxt_addr;
  end

  assign last_addr = mpd_pkg::len_t'(rd.addr) + mpd_pkg::len_t'(1) == slot_len;

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      busy         <= 1'b0;
      issuing      <= 1'b0;
      act_slot     <= '0;
      nxt_addr     <= '0;
      rd_pend      <= 1'b0;
      rd_pend_last <= 1'b0;
      tx_valid     <= 1'b0;
      tx_last      <= 1'b0;
      free_en      <= 1'b0;
    end else begin
      if (pop) begin
        busy     <= 1'b1;
        act_slot <= q[rptr];
        issuing  <= !last_addr;
        nxt_addr <= mpd_pkg::addr_t'(1);
      end else if (issuing) begin
        nxt_addr <= nxt_addr + mpd_pkg::addr_t'(1);
        if (last_addr)
          issuing <= 1'b0;
      end
      // Engine stays busy until the final byte has left
      if (tx_last)
        busy <= 1'b0;
      // Two-stage pipe from address to output byte
      rd_pend      <= rd.en;
      rd_pend_last <= rd.en && last_addr;
      tx_valid     <= rd_pend;
      tx_last      <= rd_pend_last;
      // Slot goes back to the table the cycle after tx_last
      free_en      <= tx_last;
    end
  end

  always_ff @(posedge CLK) begin
    tx_data <= rd_data;
  end

  // act_slot only changes at the next pop, which comes no earlier than this release
  always_comb begin
    tx_free.en   = free_en;
    tx_free.slot = act_slot;
  end

  // Queue never overflows, one entry per slot is enough
  a_no_push_full: assert property (@(posedge CLK) disable iff (!RST_N)
    push |-> count != mpd_pkg::NUM_SLOTS)
    else $error("push into full transmit queue");

endmodule

`default_nettype wire

// File: verilog.f
mpd_pkg.sv
slot_table.sv
header_capture.sv
rx_dealer.sv
tx_engine.sv
mpd_top.sv
tb_mpd.sv
